//--- common/calc_pkg.sv
package calc_pkg;

    localparam int DATA_W     = 32;
    localparam int BCD_DIGITS = 10;
    localparam int NUM_DIGITS = 10;
    localparam int DIGIT_W    = $clog2(NUM_DIGITS);
    localparam int CNT_W      = $clog2(DATA_W + 1);  // conversion step counter
    localparam int OP_W       = 3;

    localparam logic [OP_W-1:0] OP_ADD = 3'd0;
    localparam logic [OP_W-1:0] OP_SUB = 3'd1;
    localparam logic [OP_W-1:0] OP_MUL = 3'd2;
    localparam logic [OP_W-1:0] OP_DIV = 3'd3;
    localparam logic [OP_W-1:0] OP_EQU = 3'd4;

    // expression FSM states
    localparam int              ST_W        = 2;
    localparam logic [ST_W-1:0] ST_IDLE     = 2'd0;
    localparam logic [ST_W-1:0] ST_OPERAND  = 2'd1;
    localparam logic [ST_W-1:0] ST_OPERATOR = 2'd2;
    localparam logic [ST_W-1:0] ST_DONE     = 2'd3;

    // index is the digit
    localparam logic [NUM_DIGITS-1:0][7:0] SEG_PATTERNS = {
        8'b1111_0110,  // 9
        8'b1111_1110,  // 8
        8'b1110_0000,  // 7
        8'b1011_1110,  // 6
        8'b1011_0110,  // 5
        8'b0110_0110,  // 4
        8'b1111_0010,  // 3
        8'b1101_1010,  // 2
        8'b0110_0000,  // 1
        8'b1111_1100   // 0
    };
    localparam logic [7:0] SEG_BLANK = 8'b0000_0000;

    localparam logic [7:0] LED_NEG = 8'b1000_0000;
    localparam logic [7:0] LED_ADD = 8'b0100_0000;
    localparam logic [7:0] LED_SUB = 8'b0010_0000;
    localparam logic [7:0] LED_MUL = 8'b0001_0000;
    localparam logic [7:0] LED_DIV = 8'b0000_1000;
    localparam logic [7:0] LED_EQU = 8'b0000_0001;

endpackage

//--- entry/digit_entry.sv
module digit_entry (
    input  logic                            rst,
    input  logic                            clk_100hz,
    input  logic [calc_pkg::NUM_DIGITS-1:0] digit_key,
    input  logic                            neg_key,
    input  logic                            term_clear,
    output logic                            digit_stb,
    output logic [calc_pkg::DATA_W-1:0]     term_mag,
    output logic                            term_neg,
    output logic [7:0]                      seg
);

    logic [calc_pkg::NUM_DIGITS:0]  key_q1;  // minus key on top bit
    logic [calc_pkg::NUM_DIGITS:0]  key_q2;
    logic                           key_rise;
    logic                           pick_neg;
    logic [calc_pkg::DIGIT_W-1:0]   pick_digit;
    logic [calc_pkg::DIGIT_W-1:0]   last_digit;
    logic                           last_hit;  // last strobe was a digit

    assign key_rise = (|key_q1) && !(|key_q2);

    // lowest index wins, minus only when no digit is down
    always_comb
    begin
        pick_digit = '0;
        pick_neg   = 1'b1;
        for (int i = calc_pkg::NUM_DIGITS - 1; i >= 0; i--)
        begin
            if (key_q1[i])
            begin
                pick_digit = calc_pkg::DIGIT_W'(i);
                pick_neg   = 1'b0;
            end
        end
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            key_q1    <= '0;
            key_q2    <= '0;
            digit_stb <= 1'b0;
            term_mag  <= '0;
            term_neg  <= 1'b0;
            last_hit  <= 1'b0;
            seg       <= calc_pkg::SEG_BLANK;
        end
        else
        begin
            key_q1    <= {neg_key, digit_key};
            key_q2    <= key_q1;
            digit_stb <= key_rise;
            if (term_clear)
            begin
                term_mag <= '0;
                term_neg <= 1'b0;
            end
            else if (key_rise)
            begin
                if (pick_neg)
                    term_neg <= 1'b1;
                else  // x10 plus the new digit, wraps
                    term_mag <= (term_mag << 3) + (term_mag << 1)
                              + {{(calc_pkg::DATA_W - calc_pkg::DIGIT_W){1'b0}}, pick_digit};
            end
            if (key_rise)
                last_hit <= !pick_neg;
            if (digit_stb && last_hit)
                seg <= calc_pkg::SEG_PATTERNS[last_digit];
        end
    end

    always_ff @(posedge rst)
    begin
        if (key_rise)
            last_digit <= pick_digit;
    end

endmodule

//--- entry/operator_entry.sv
module operator_entry (
    input  logic                        rst,
    input  logic                        clk_100hz,
    input  logic                        add_key,
    input  logic                        sub_key,
    input  logic                        mul_key,
    input  logic                        div_key,
    input  logic                        equ_key,
    output logic                        op_stb,
    output logic [calc_pkg::OP_W-1:0]   op_code,
    output logic [7:0]                  led
);

    logic [4:0]                 key_q1;  // add on bit 0
    logic [4:0]                 key_q2;
    logic                       key_rise;
    logic [calc_pkg::OP_W-1:0]  pick_op;
    logic [7:0]                 led_pat;

    assign key_rise = (|key_q1) && !(|key_q2);

    always_comb
    begin
        if (key_q1[0])
            pick_op = calc_pkg::OP_ADD;
        else if (key_q1[1])
            pick_op = calc_pkg::OP_SUB;
        else if (key_q1[2])
            pick_op = calc_pkg::OP_MUL;
        else if (key_q1[3])
            pick_op = calc_pkg::OP_DIV;
        else
            pick_op = calc_pkg::OP_EQU;
    end

    always_comb
    begin
        case (op_code)
            calc_pkg::OP_ADD: led_pat = calc_pkg::LED_ADD;
            calc_pkg::OP_SUB: led_pat = calc_pkg::LED_SUB;
            calc_pkg::OP_MUL: led_pat = calc_pkg::LED_MUL;
            calc_pkg::OP_DIV: led_pat = calc_pkg::LED_DIV;
            calc_pkg::OP_EQU: led_pat = calc_pkg::LED_EQU;
            default:          led_pat = 8'h00;
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            key_q1 <= '0;
            key_q2 <= '0;
            op_stb <= 1'b0;
            led    <= 8'h00;
        end
        else
        begin
            key_q1 <= {equ_key, div_key, mul_key, sub_key, add_key};
            key_q2 <= key_q1;
            op_stb <= key_rise;
            if (op_stb)
                led <= led_pat;  // one cycle behind the strobe
        end
    end

    always_ff @(posedge rst)
    begin
        if (key_rise)
            op_code <= pick_op;
    end

endmodule

//--- rtl/term_accumulator.sv
module term_accumulator (
    input  logic                        rst,
    input  logic                        clk_100hz,
    input  logic                        digit_stb,
    input  logic                        op_stb,
    input  logic [calc_pkg::OP_W-1:0]   op_code,
    input  logic [calc_pkg::DATA_W-1:0] term_mag,
    input  logic                        term_neg,
    output logic                        term_clear,
    output logic                        conv_start,
    output logic [calc_pkg::DATA_W-1:0] acc_value
);

    logic [calc_pkg::ST_W-1:0]          state;
    logic [calc_pkg::OP_W-1:0]          pend_op;  // operator waiting for its right term
    logic signed [calc_pkg::DATA_W-1:0] acc;
    logic signed [calc_pkg::DATA_W-1:0] term_s;
    logic signed [calc_pkg::DATA_W-1:0] alu;

    assign acc_value = acc;
    assign term_s    = term_neg ? -$signed(term_mag) : $signed(term_mag);

    // left to right, no precedence
    always_comb
    begin
        case (pend_op)
            calc_pkg::OP_ADD: alu = acc + term_s;
            calc_pkg::OP_SUB: alu = acc - term_s;
            calc_pkg::OP_MUL: alu = acc * term_s;
            calc_pkg::OP_DIV:
            begin
                if (term_s == '0)
                    alu = '0;  // x / 0 reads as 0
                else
                    alu = acc / term_s;  // truncates toward zero
            end
            default:          alu = term_s;
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state      <= calc_pkg::ST_IDLE;
            pend_op    <= calc_pkg::OP_ADD;
            acc        <= '0;
            term_clear <= 1'b0;
            conv_start <= 1'b0;
        end
        else
        begin
            term_clear <= 1'b0;
            conv_start <= term_clear && (state == calc_pkg::ST_DONE);
            case (state)
                calc_pkg::ST_IDLE, calc_pkg::ST_DONE:
                begin
                    if (digit_stb)
                    begin
                        acc     <= '0;  // fresh expression
                        pend_op <= calc_pkg::OP_ADD;
                        state   <= calc_pkg::ST_OPERAND;
                    end
                end
                calc_pkg::ST_OPERAND:
                begin
                    if (op_stb)
                    begin
                        acc        <= alu;
                        term_clear <= 1'b1;
                        if (op_code == calc_pkg::OP_EQU)
                            state <= calc_pkg::ST_DONE;
                        else
                        begin
                            pend_op <= op_code;
                            state   <= calc_pkg::ST_OPERATOR;
                        end
                    end
                end
                calc_pkg::ST_OPERATOR:
                begin
                    if (digit_stb)
                        state <= calc_pkg::ST_OPERAND;
                end
                default: state <= calc_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/result_bcd.sv
module result_bcd (
    input  logic                              rst,
    input  logic                              clk_100hz,
    input  logic                              conv_start,
    input  logic [calc_pkg::DATA_W-1:0]       acc_value,
    output logic [4*calc_pkg::BCD_DIGITS-1:0] result_bcd,
    output logic                              result_neg,
    output logic                              result_valid
);

    logic [calc_pkg::CNT_W-1:0]          step_cnt;  // shifts still to do
    logic                                sign_q;
    logic [calc_pkg::DATA_W-1:0]         mag_work;
    logic [4*calc_pkg::BCD_DIGITS-1:0]   bcd_work;
    logic [4*calc_pkg::BCD_DIGITS-1:0]   bcd_adj;
    logic [4*calc_pkg::BCD_DIGITS-1:0]   bcd_next;

    // add 3 to every digit of 5 or more, then shift in the next bit
    always_comb
    begin
        bcd_adj = bcd_work;
        for (int i = 0; i < calc_pkg::BCD_DIGITS; i++)
        begin
            if (bcd_adj[4*i +: 4] >= 4'd5)
                bcd_adj[4*i +: 4] = bcd_adj[4*i +: 4] + 4'd3;
        end
        bcd_next = {bcd_adj[4*calc_pkg::BCD_DIGITS-2:0], mag_work[calc_pkg::DATA_W-1]};
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            step_cnt     <= '0;
            result_bcd   <= '0;
            result_neg   <= 1'b0;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= 1'b0;
            if (conv_start)
                step_cnt <= calc_pkg::CNT_W'(calc_pkg::DATA_W);
            else if (step_cnt != '0)
            begin
                step_cnt <= step_cnt - 1'b1;
                if (step_cnt == 1)  // last shift
                begin
                    result_bcd   <= bcd_next;
                    result_neg   <= sign_q;
                    result_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge rst)
    begin
        if (conv_start)
        begin
            sign_q   <= acc_value[calc_pkg::DATA_W-1];
            mag_work <= acc_value[calc_pkg::DATA_W-1] ? -acc_value : acc_value;  // 2^31 stays 2^31
            bcd_work <= '0;
        end
        else if (step_cnt != '0)
        begin
            mag_work <= mag_work << 1;
            bcd_work <= bcd_next;
        end
    end

endmodule

//--- rtl/calculator.sv
module calculator (
    input  logic                                 rst,
    input  logic                                 clk_100hz,
    input  logic [calc_pkg::NUM_DIGITS-1:0]      digit_key,
    input  logic                                 neg_key,
    input  logic                                 add_key,
    input  logic                                 sub_key,
    input  logic                                 mul_key,
    input  logic                                 div_key,
    input  logic                                 equ_key,
    output logic [7:0]                           seg,
    output logic [7:0]                           led,
    output logic [4*calc_pkg::BCD_DIGITS-1:0]    result_bcd,
    output logic                                 result_neg,
    output logic                                 result_valid
);

    logic                          digit_stb;
    logic [calc_pkg::DATA_W-1:0]   term_mag;
    logic                          term_neg;
    logic                          term_clear;
    logic                          op_stb;
    logic [calc_pkg::OP_W-1:0]     op_code;
    logic [7:0]                    op_led;
    logic                          conv_start;
    logic [calc_pkg::DATA_W-1:0]   acc_value;

    assign led = op_led | (term_neg ? calc_pkg::LED_NEG : 8'h00);  // minus lamp on top bit

    digit_entry u_digit_entry (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .digit_key  (digit_key),
        .neg_key    (neg_key),
        .term_clear (term_clear),
        .digit_stb  (digit_stb),
        .term_mag   (term_mag),
        .term_neg   (term_neg),
        .seg        (seg)
    );

    operator_entry u_operator_entry (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .add_key   (add_key),
        .sub_key   (sub_key),
        .mul_key   (mul_key),
        .div_key   (div_key),
        .equ_key   (equ_key),
        .op_stb    (op_stb),
        .op_code   (op_code),
        .led       (op_led)
    );

    term_accumulator u_term_accumulator (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .digit_stb  (digit_stb),
        .op_stb     (op_stb),
        .op_code    (op_code),
        .term_mag   (term_mag),
        .term_neg   (term_neg),
        .term_clear (term_clear),
        .conv_start (conv_start),
        .acc_value  (acc_value)
    );

    result_bcd u_result_bcd (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .conv_start   (conv_start),
        .acc_value    (acc_value),
        .result_bcd   (result_bcd),
        .result_neg   (result_neg),
        .result_valid (result_valid)
    );

endmodule

//--- verif/calculator_properties.sv
module calculator_properties (
    input logic       rst,
    input logic       clk_100hz,
    input logic [7:0] led,
    input logic       result_valid
);

    // one pulse per result
    valid_single_cycle: assert property (
        @(posedge rst) disable iff (clk_100hz)
        result_valid |=> !result_valid
    )
    else $error("result_valid stayed high for two cycles");

    op_led_onehot: assert property (
        @(posedge rst) disable iff (clk_100hz)
        $onehot0(led[6:0])
    )
    else $error("more than one operator LED lit");

    valid_low_after_reset: assert property (
        @(posedge rst)
        $fell(clk_100hz) |-> !result_valid
    )
    else $error("result_valid high right after reset release");

endmodule

bind calculator calculator_properties u_calculator_properties (
    .rst          (rst),
    .clk_100hz    (clk_100hz),
    .led          (led),
    .result_valid (result_valid)
);

//--- verif/calculator_tb.sv
module calculator_tb;

    localparam int HALF_PERIOD    = 2;
    localparam int RESET_CYCLES   = 8;
    localparam int HOLD_CYCLES    = 3;   // key high, then key low
    localparam int IDLE_CYCLES    = 20;
    localparam int RESULT_TIMEOUT = 60;
    localparam int NUM_EXPR       = 200;
    localparam int KEY_NEG        = 10;  // digit keys are 0 to 9
    localparam int KEY_ADD        = 11;  // add, sub, mul, div, equ follow in order

    logic                                rst;        // clock
    logic                                clk_100hz;  // reset, active high
    logic [calc_pkg::NUM_DIGITS-1:0]     digit_key;
    logic                                neg_key;
    logic                                add_key;
    logic                                sub_key;
    logic                                mul_key;
    logic                                div_key;
    logic                                equ_key;
    logic [7:0]                          seg;
    logic [7:0]                          led;
    logic [4*calc_pkg::BCD_DIGITS-1:0]   result_bcd;
    logic                                result_neg;
    logic                                result_valid;

    logic [31:0] rng_state = 32'd48594;
    logic [7:0]  exp_seg;
    logic        exp_neg;
    int          err_cnt;

    calculator u_calculator (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .digit_key    (digit_key),
        .neg_key      (neg_key),
        .add_key      (add_key),
        .sub_key      (sub_key),
        .mul_key      (mul_key),
        .div_key      (div_key),
        .equ_key      (equ_key),
        .seg          (seg),
        .led          (led),
        .result_bcd   (result_bcd),
        .result_neg   (result_neg),
        .result_valid (result_valid)
    );

    initial
    begin
        rst = 1'b0;
        forever #HALF_PERIOD rst = ~rst;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int rand_below(input int n);
        rng_state = xorshift(rng_state);
        return int'(rng_state % n);
    endfunction

    // signed 32-bit, wraps; x / 0 gives 0
    function automatic logic [31:0] apply_op(input int op, input logic signed [31:0] a,
                                             input logic signed [31:0] b);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a * b;
            default:
            begin
                if (b == 0)
                    return 0;
                else if (b == -1)
                    return -a;  // avoids the host trap on min / -1
                else
                    return a / b;
            end
        endcase
    endfunction

    function automatic logic [39:0] to_bcd(input logic [31:0] mag);
        logic [39:0] bcd;
        bcd = '0;
        for (int i = 0; i < calc_pkg::BCD_DIGITS; i++)
        begin
            bcd[4*i +: 4] = 4'(mag % 10);
            mag = mag / 10;
        end
        return bcd;
    endfunction

    function automatic logic [7:0] op_pattern(input int op);
        case (op)
            0:       return calc_pkg::LED_ADD;
            1:       return calc_pkg::LED_SUB;
            2:       return calc_pkg::LED_MUL;
            3:       return calc_pkg::LED_DIV;
            default: return calc_pkg::LED_EQU;
        endcase
    endfunction

    task automatic fail_now(input string msg);
        err_cnt++;
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        assert (expected === actual)
        else fail_now($sformatf("ERR %s expected %0h actual %0h", name, expected, actual));
    endtask

    task automatic drive_key(input int key, input logic level);
        logic [calc_pkg::NUM_DIGITS-1:0] one_hot;
        one_hot = '0;
        if (key < calc_pkg::NUM_DIGITS)
        begin
            one_hot[key] = level;
            digit_key <= one_hot;
        end
        else
        begin
            case (key)
                KEY_NEG:     neg_key <= level;
                KEY_ADD:     add_key <= level;
                KEY_ADD + 1: sub_key <= level;
                KEY_ADD + 2: mul_key <= level;
                KEY_ADD + 3: div_key <= level;
                default:     equ_key <= level;
            endcase
        end
    endtask

    // full press, ends between edges so outputs are settled
    task automatic press(input int key);
        @(posedge rst);
        drive_key(key, 1'b1);
        repeat (HOLD_CYCLES) @(posedge rst);
        drive_key(key, 1'b0);
        repeat (HOLD_CYCLES) @(posedge rst);
        @(negedge rst);
    endtask

    task automatic press_digit(input int d);
        press(d);
        exp_seg = calc_pkg::SEG_PATTERNS[d];
        check_val($sformatf("digit %0d seg", d), exp_seg, seg);
        check_val($sformatf("digit %0d minus led", d), exp_neg, led[7]);
    endtask

    task automatic press_minus();
        press(KEY_NEG);
        exp_neg = 1'b1;
        check_val("minus seg", exp_seg, seg);
        check_val("minus led", exp_neg, led[7]);
    endtask

    task automatic press_op(input int op);
        press(KEY_ADD + op);
        exp_neg = 1'b0;  // term cleared once the operator is taken
        check_val($sformatf("op %0d led", op), op_pattern(op) & 8'h7f, led & 8'h7f);
        check_val($sformatf("op %0d minus led", op), exp_neg, led[7]);
        check_val($sformatf("op %0d seg", op), exp_seg, seg);
    endtask

    task automatic enter_term(input logic [31:0] mag, input bit neg, input bit neg_first);
        int digits[$];
        logic [31:0] m;
        m = mag;
        do
        begin
            digits.push_front(int'(m % 10));
            m = m / 10;
        end
        while (m != 0);
        if (neg && neg_first)
            press_minus();
        foreach (digits[i])
            press_digit(digits[i]);
        if (neg && !neg_first)
            press_minus();
    endtask

    task automatic finish_expr(input string name, input logic [31:0] expected);
        logic [31:0] mag;
        int          waited;
        mag = expected[31] ? -expected : expected;
        press_op(4);
        waited = 2 * HOLD_CYCLES;
        while (!result_valid && waited < RESULT_TIMEOUT)
        begin
            @(negedge rst);
            waited++;
        end
        assert (result_valid)
        else fail_now($sformatf("%s gave no result within %0d cycles", name, RESULT_TIMEOUT));
        check_val({name, " bcd"}, to_bcd(mag), result_bcd);
        check_val({name, " sign"}, expected[31], result_neg);
    endtask

    task automatic random_expr(input int idx);
        int          nterms;
        int          ndig;
        int          op;
        bit          neg;
        logic [31:0] mag;
        logic [31:0] term;
        logic [31:0] acc;
        op     = 0;
        acc    = '0;
        nterms = 1 + rand_below(4);
        for (int t = 0; t < nterms; t++)
        begin
            if (t > 0)
            begin
                op = rand_below(4);
                press_op(op);
            end
            ndig = 1 + rand_below(4);
            mag  = rand_below(10 ** ndig);
            neg  = (rand_below(4) == 0);
            enter_term(mag, neg, rand_below(2) == 0);
            term = neg ? -mag : mag;
            acc  = (t == 0) ? term : apply_op(op, acc, term);
        end
        finish_expr($sformatf("expr %0d", idx), acc);
    endtask

    initial
    begin
        digit_key = '0;
        neg_key   = 1'b0;
        add_key   = 1'b0;
        sub_key   = 1'b0;
        mul_key   = 1'b0;
        div_key   = 1'b0;
        equ_key   = 1'b0;
        clk_100hz = 1'b1;
        exp_seg   = calc_pkg::SEG_BLANK;
        exp_neg   = 1'b0;
        err_cnt   = 0;
        repeat (RESET_CYCLES) @(posedge rst);
        clk_100hz <= 1'b0;
        @(negedge rst);
        check_val("reset seg", calc_pkg::SEG_BLANK, seg);
        check_val("reset led", 8'h00, led);
        repeat (IDLE_CYCLES)
        begin
            @(negedge rst);
            assert (!result_valid)
            else fail_now("result_valid pulsed before any expression was entered");
        end

        enter_term(123, 1'b0, 1'b1);
        press_op(3);
        enter_term(0, 1'b0, 1'b1);
        finish_expr("divide by zero", 32'd0);
        enter_term(65536, 1'b0, 1'b1);
        press_op(2);
        enter_term(32768, 1'b1, 1'b1);
        finish_expr("most negative", 32'h8000_0000);
        enter_term(2147483647, 1'b0, 1'b1);
        press_op(0);
        enter_term(1, 1'b0, 1'b0);
        finish_expr("add wrap", 32'h8000_0000);
        enter_term(9999, 1'b0, 1'b1);
        press_op(2);
        enter_term(9999, 1'b0, 1'b1);
        press_op(2);
        enter_term(9999, 1'b0, 1'b1);
        finish_expr("mul wrap", -1027349969);

        for (int i = 0; i < NUM_EXPR; i++)
            random_expr(i);

        if (err_cnt == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- files.f
common/calc_pkg.sv
entry/digit_entry.sv
entry/operator_entry.sv
rtl/term_accumulator.sv
rtl/result_bcd.sv
rtl/calculator.sv
verif/calculator_properties.sv
verif/calculator_tb.sv

//--- Bender.yml
package:
  name: calculator

sources:
  - common/calc_pkg.sv
  - entry/digit_entry.sv
  - entry/operator_entry.sv
  - rtl/term_accumulator.sv
  - rtl/result_bcd.sv
  - rtl/calculator.sv
  - target: test
    files:
      - verif/calculator_properties.sv
      - verif/calculator_tb.sv
